//--- hdl/vga_pkg.sv
// VGA frame-buffer shared types
// Core request and response words, raster position
// and video output bundles used across both clock domains

package vga_pkg;

    // ==============================
    // Core side
    // ==============================

    // Word address width on the core bus
    localparam int CORE_ADDR_W = 30;

    // Single-cycle request strobe from the core
    typedef struct packed {
        logic                   valid;
        logic                   we;
        logic [CORE_ADDR_W-1:0] addr;
        logic [31:0]            data;
        logic [3:0]             byteena;
    } core_req_t;

    // Read response, one per read request
    typedef struct packed {
        logic        valid;
        // Address fell outside the frame buffer
        logic        err;
        logic [31:0] data;
    } core_rsp_t;

    // ==============================
    // Display side
    // ==============================

    // Raster position plus syncs, all in one cycle
    typedef struct packed {
        logic [15:0] x;
        logic [15:0] y;
        logic        de;
        logic        hsync_n;
        logic        vsync_n;
    } raster_t;

    // Registered video outputs
    typedef struct packed {
        logic hsync_n;
        logic vsync_n;
        logic de;
        logic pixel;
    } video_t;

endpackage

//--- hdl/vga_core_port.sv
// VGA core port
// Registers core requests, checks them against the frame-buffer window,
// issues byte-enabled writes and returns read data two cycles later

`timescale 1ns/1ps

module vga_core_port #(
    parameter int   MEM_WORDS = 9600,
    localparam int  ADDR_W    = $clog2(MEM_WORDS)
) (
    input  logic                clock_a,
    input  logic                arst_n,
    input  vga_pkg::core_req_t  core_req,
    output logic [ADDR_W-1:0]   mem_addr,
    output logic [31:0]         mem_data,
    output logic [3:0]          mem_byteena,
    output logic                mem_wren,
    input  logic [31:0]         q_a,
    output vga_pkg::core_rsp_t  core_rsp
);

    localparam int AW = vga_pkg::CORE_ADDR_W;
    // First word past the buffer
    localparam logic [AW-1:0] WIN_END = AW'(MEM_WORDS);

    logic in_win;
    // Stage 1, request registered
    logic rd_q;
    logic err_q;
    // Stage 2, lines up with q_a
    logic rsp_valid_q;
    logic rsp_err_q;

    assign in_win = core_req.addr < WIN_END;

    // ==============================
    // Request stage
    // ==============================
    always_ff @(posedge clock_a or negedge arst_n) begin
        if (!arst_n) begin
            mem_wren <= 1'b0;
            rd_q     <= 1'b0;
            err_q    <= 1'b0;
        end else begin
            // Out-of-window writes simply vanish
            mem_wren <= core_req.valid & core_req.we & in_win;
            rd_q     <= core_req.valid & ~core_req.we;
            err_q    <= core_req.valid & ~core_req.we & ~in_win;
        end
    end

    // Write payload and address, no reset
    always_ff @(posedge clock_a) begin
        // Park out-of-window accesses on word 0 so q_a stays defined
        mem_addr    <= in_win ? core_req.addr[ADDR_W-1:0] : '0;
        mem_data    <= core_req.data;
        mem_byteena <= core_req.byteena;
    end

    // ==============================
    // Response stage
    // ==============================
    always_ff @(posedge clock_a or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid_q <= 1'b0;
            rsp_err_q   <= 1'b0;
        end else begin
            rsp_valid_q <= rd_q;
            rsp_err_q   <= err_q;
        end
    end

    // Data straight from the RAM output register
    assign core_rsp.valid = rsp_valid_q;
    assign core_rsp.err   = rsp_err_q;
    assign core_rsp.data  = rsp_err_q ? 32'd0 : q_a;

endmodule

//--- hdl/vga_mem.sv
// VGA frame-buffer memory
// Dual-clock byte array, 32-bit words
// Port A: byte-enabled write and registered read on clock_a
// Port B: registered read for the display on clock_b

`timescale 1ns/1ps

module vga_mem #(
    parameter int   MEM_WORDS = 9600,
    localparam int  ADDR_W    = $clog2(MEM_WORDS)
) (
    input  logic                clock_a,
    input  logic                clock_b,
    // Core write
    input  logic [31:0]         data_a,
    input  logic [ADDR_W-1:0]   address_a,
    input  logic [3:0]          byteena_a,
    input  logic                wren_a,
    // Core read
    output logic [31:0]         q_a,
    // Display read
    input  logic [ADDR_W-1:0]   address_b,
    output logic [31:0]         q_b
);

    // Byte count, 4 per word
    localparam int MEM_BYTES = MEM_WORDS * 4;

    // ==============================
    // Storage
    // ==============================

    // Behavioural model
    // byte n of word w sits at index {w, n}
    logic [7:0] mem_array [MEM_BYTES];

    // ==============================
    // Port A
    // ==============================
    always_ff @(posedge clock_a) begin
        // Per lane write under byte enable
        if (wren_a) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (byteena_a[lane]) begin
                    mem_array[{address_a, lane[1:0]}] <= data_a[8*lane +: 8];
                end
            end
        end
        // Read returns the contents from before this edge
        q_a <= {mem_array[{address_a, 2'd3}],
                mem_array[{address_a, 2'd2}],
                mem_array[{address_a, 2'd1}],
                mem_array[{address_a, 2'd0}]};
    end

    // ==============================
    // Port B
    // ==============================

    // Display fetch, read only
    always_ff @(posedge clock_b) begin
        q_b <= {mem_array[{address_b, 2'd3}],
                mem_array[{address_b, 2'd2}],
                mem_array[{address_b, 2'd1}],
                mem_array[{address_b, 2'd0}]};
    end

endmodule

//--- hdl/vga_raster_timing.sv
// VGA raster timing generator
// Horizontal and vertical counters, active-low sync pulses
// and display enable, all registered

`timescale 1ns/1ps

module vga_raster_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic                clock_b,
    input  logic                arst_n,
    output vga_pkg::raster_t    raster
);

    // ==============================
    // Mode constants
    // ==============================
    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    // Horizontal markers, in pixels
    localparam logic [15:0] H_ACT_END = 16'(H_ACTIVE);
    localparam logic [15:0] HS_START  = 16'(H_ACTIVE + H_FRONT);
    localparam logic [15:0] HS_END    = 16'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam logic [15:0] H_LAST    = 16'(H_TOTAL - 1);

    // Vertical markers, in lines
    localparam logic [15:0] V_ACT_END = 16'(V_ACTIVE);
    localparam logic [15:0] VS_START  = 16'(V_ACTIVE + V_FRONT);
    localparam logic [15:0] VS_END    = 16'(V_ACTIVE + V_FRONT + V_SYNC);
    localparam logic [15:0] V_LAST    = 16'(V_TOTAL - 1);

    logic [15:0] h_cnt;
    logic [15:0] v_cnt;
    logic        line_end;
    logic        frame_end;
    logic        h_active;
    logic        v_active;
    logic        h_sync;
    logic        v_sync;

    assign line_end  = h_cnt == H_LAST;
    assign frame_end = v_cnt == V_LAST;

    // Region decode from the counters
    assign h_active = h_cnt < H_ACT_END;
    assign v_active = v_cnt < V_ACT_END;
    assign h_sync   = (h_cnt >= HS_START) && (h_cnt < HS_END);
    assign v_sync   = (v_cnt >= VS_START) && (v_cnt < VS_END);

    // ==============================
    // Counters
    // ==============================
    always_ff @(posedge clock_b or negedge arst_n) begin
        if (!arst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (line_end) begin
            // Vertical steps once per line
            h_cnt <= '0;
            v_cnt <= frame_end ? '0 : v_cnt + 16'd1;
        end else begin
            h_cnt <= h_cnt + 16'd1;
        end
    end

    // Output register, one cycle behind the counters
    always_ff @(posedge clock_b or negedge arst_n) begin
        if (!arst_n) begin
            raster <= '{x: '0, y: '0, de: 1'b0, hsync_n: 1'b1, vsync_n: 1'b1};
        end else begin
            raster.x       <= h_cnt;
            raster.y       <= v_cnt;
            raster.de      <= h_active && v_active;
            raster.hsync_n <= ~h_sync;
            raster.vsync_n <= ~v_sync;
        end
    end

endmodule

//--- hdl/vga_pixel_fetch.sv
// VGA pixel fetcher
// Reads one frame-buffer word per 32 pixels and shifts it out,
// bit 0 leftmost, with syncs and de delayed to stay aligned

`timescale 1ns/1ps

module vga_pixel_fetch #(
    parameter int   H_ACTIVE  = 640,
    parameter int   MEM_WORDS = 9600,
    localparam int  ADDR_W    = $clog2(MEM_WORDS)
) (
    input  logic                clock_b,
    input  logic                arst_n,
    input  vga_pkg::raster_t    raster,
    output logic [ADDR_W-1:0]   address_b,
    input  logic [31:0]         q_b,
    output vga_pkg::video_t     video
);

    // Words per line, H_ACTIVE is a multiple of 32
    localparam int WORDS_PER_LINE = H_ACTIVE / 32;

    logic        fetch;
    logic [31:0] word_idx;

    // Delay stage, matches the RAM read latency
    logic        fetch_q;
    logic        de_q;
    logic        hsync_n_q;
    logic        vsync_n_q;

    logic [31:0] shift_q;
    logic        pixel_next;

    // ==============================
    // Word address
    // ==============================

    // New word at every 32-pixel boundary of the active area
    assign fetch = raster.de && (raster.x[4:0] == 5'd0);

    // y * words per line + x / 32
    assign word_idx = 32'(raster.y) * 32'(WORDS_PER_LINE) + 32'(raster.x[15:5]);

    // Idle address outside fetch cycles
    assign address_b = fetch ? word_idx[ADDR_W-1:0] : '0;

    // ==============================
    // Delay stage
    // ==============================
    always_ff @(posedge clock_b or negedge arst_n) begin
        if (!arst_n) begin
            fetch_q   <= 1'b0;
            de_q      <= 1'b0;
            hsync_n_q <= 1'b1;
            vsync_n_q <= 1'b1;
        end else begin
            fetch_q   <= fetch;
            de_q      <= raster.de;
            hsync_n_q <= raster.hsync_n;
            vsync_n_q <= raster.vsync_n;
        end
    end

    // ==============================
    // Shift register
    // ==============================

    // Pixel data only, no reset
    always_ff @(posedge clock_b) begin
        if (fetch_q) begin
            // Bit 0 goes out now, keep the rest
            shift_q <= {1'b0, q_b[31:1]};
        end else if (de_q) begin
            shift_q <= {1'b0, shift_q[31:1]};
        end
    end

    // Fresh word takes the first bit directly from the RAM
    assign pixel_next = fetch_q ? q_b[0] : shift_q[0];

    // ==============================
    // Video output
    // ==============================
    always_ff @(posedge clock_b or negedge arst_n) begin
        if (!arst_n) begin
            video <= '{hsync_n: 1'b1, vsync_n: 1'b1, de: 1'b0, pixel: 1'b0};
        end else begin
            video.hsync_n <= hsync_n_q;
            video.vsync_n <= vsync_n_q;
            video.de      <= de_q;
            // Blank outside the active area
            video.pixel   <= de_q & pixel_next;
        end
    end

endmodule

//--- hdl/vga_display_top.sv
// VGA display subsystem top
// Core port and frame buffer on clock_a,
// raster timing and pixel fetch on clock_b

`timescale 1ns/1ps

module vga_display_top #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic                clock_a,
    input  logic                clock_b,
    input  logic                arst_n,
    input  vga_pkg::core_req_t  core_req,
    output vga_pkg::core_rsp_t  core_rsp,
    output vga_pkg::video_t     video
);

    // One bit per pixel, 32 pixels per word
    localparam int MEM_WORDS = H_ACTIVE * V_ACTIVE / 32;
    localparam int ADDR_W    = $clog2(MEM_WORDS);

    // Core domain
    logic [ADDR_W-1:0] mem_addr;
    logic [31:0]       mem_data;
    logic [3:0]        mem_byteena;
    logic              mem_wren;
    logic [31:0]       q_a;

    // Display domain
    vga_pkg::raster_t  raster;
    logic [ADDR_W-1:0] address_b;
    logic [31:0]       q_b;

    // ==============================
    // Core side
    // ==============================
    vga_core_port #(
        .MEM_WORDS  (MEM_WORDS)
    ) vga_core_port_inst (
        .clock_a    (clock_a),
        .arst_n     (arst_n),
        .core_req   (core_req),
        .mem_addr   (mem_addr),
        .mem_data   (mem_data),
        .mem_byteena(mem_byteena),
        .mem_wren   (mem_wren),
        .q_a        (q_a),
        .core_rsp   (core_rsp)
    );

    // Frame buffer spans both domains
    vga_mem #(
        .MEM_WORDS  (MEM_WORDS)
    ) vga_mem_inst (
        .clock_a    (clock_a),
        .clock_b    (clock_b),
        .data_a     (mem_data),
        .address_a  (mem_addr),
        .byteena_a  (mem_byteena),
        .wren_a     (mem_wren),
        .q_a        (q_a),
        .address_b  (address_b),
        .q_b        (q_b)
    );

    // ==============================
    // Display side
    // ==============================
    vga_raster_timing #(
        .H_ACTIVE   (H_ACTIVE),
        .H_FRONT    (H_FRONT),
        .H_SYNC     (H_SYNC),
        .H_BACK     (H_BACK),
        .V_ACTIVE   (V_ACTIVE),
        .V_FRONT    (V_FRONT),
        .V_SYNC     (V_SYNC),
        .V_BACK     (V_BACK)
    ) vga_raster_timing_inst (
        .clock_b    (clock_b),
        .arst_n     (arst_n),
        .raster     (raster)
    );

    vga_pixel_fetch #(
        .H_ACTIVE   (H_ACTIVE),
        .MEM_WORDS  (MEM_WORDS)
    ) vga_pixel_fetch_inst (
        .clock_b    (clock_b),
        .arst_n     (arst_n),
        .raster     (raster),
        .address_b  (address_b),
        .q_b        (q_b),
        .video      (video)
    );

endmodule

//--- sim/vga_display_checker.sv
// VGA display protocol checker
// Bound to the display top
// Core response timing, reset values and sync against display enable

`timescale 1ns/1ps

module vga_display_checker (
    input logic               clock_a,
    input logic               clock_b,
    input logic               arst_n,
    input vga_pkg::core_req_t core_req,
    input vga_pkg::core_rsp_t core_rsp,
    input vga_pkg::video_t    video,
    input logic               mem_wren
);

    // Failure counts per clock domain
    int fails_a = 0;
    int fails_b = 0;
    int assert_fails;

    logic rd_strobe;
    logic wr_strobe;

    assign assert_fails = fails_a + fails_b;
    assign rd_strobe    = core_req.valid & ~core_req.we;
    assign wr_strobe    = core_req.valid & core_req.we;

    // ==============================
    // Reset values
    // ==============================
    a_core_reset: assert property (@(posedge clock_a)
        !arst_n |-> (!core_rsp.valid && !mem_wren))
        else begin
            $error("core side left its reset values during reset");
            fails_a++;
        end

    a_video_reset: assert property (@(posedge clock_b)
        !arst_n |-> (video.hsync_n && video.vsync_n && !video.de && !video.pixel))
        else begin
            $error("video outputs left their reset values during reset");
            fails_b++;
        end

    // ==============================
    // Core response timing
    // ==============================

    // Every read answered two cycles later
    a_rsp_after_read: assert property (@(posedge clock_a) disable iff (!arst_n)
        $past(rd_strobe, 2) |-> core_rsp.valid)
        else begin
            $error("read strobe without a response two cycles later");
            fails_a++;
        end

    a_rsp_needs_read: assert property (@(posedge clock_a) disable iff (!arst_n)
        core_rsp.valid |-> $past(rd_strobe, 2))
        else begin
            $error("response without a read two cycles earlier");
            fails_a++;
        end

    a_no_rsp_after_write: assert property (@(posedge clock_a) disable iff (!arst_n)
        $past(wr_strobe, 2) |-> !core_rsp.valid)
        else begin
            $error("response after a write");
            fails_a++;
        end

    // Active video never overlaps a sync pulse
    a_de_outside_sync: assert property (@(posedge clock_b) disable iff (!arst_n)
        video.de |-> (video.hsync_n && video.vsync_n))
        else begin
            $error("de high during a sync pulse");
            fails_b++;
        end

endmodule

//--- sim/vga_display_tb.sv
// VGA display subsystem testbench
// Core reads and writes against a shadow buffer,
// raster timing over one frame and full-frame pixel capture

`timescale 1ns/1ps

module vga_display_tb;

    // ==============================
    // Mode and derived constants
    // ==============================
    localparam int H_ACTIVE     = 64;
    localparam int H_FRONT      = 4;
    localparam int H_SYNC       = 8;
    localparam int H_BACK       = 4;
    localparam int V_ACTIVE     = 6;
    localparam int V_FRONT      = 1;
    localparam int V_SYNC       = 2;
    localparam int V_BACK       = 1;
    localparam int LINE_CYC     = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int FRAME_CYC    = LINE_CYC * (V_ACTIVE + V_FRONT + V_SYNC + V_BACK);
    localparam int MEM_WORDS    = H_ACTIVE * V_ACTIVE / 32;
    localparam int SH_AW        = $clog2(MEM_WORDS);
    localparam int WPL          = H_ACTIVE / 32;
    localparam int CLK_PERIOD   = 10;
    localparam int WATCHDOG_CYC = 8 * FRAME_CYC + 2000;

    // Expected read response with its issue cycle
    typedef struct packed {
        logic [31:0] cyc;
        logic        err;
        logic [31:0] data;
    } exp_rsp_t;

    logic               clock_a = 1'b0;
    logic               clock_b = 1'b0;
    logic               arst_n;
    vga_pkg::core_req_t core_req;
    vga_pkg::core_rsp_t core_rsp;
    vga_pkg::video_t    video;

    integer      seed = 32'ha9fc_0ec8;
    logic [31:0] shadow [MEM_WORDS];
    exp_rsp_t    exp_q [$];
    int          rd_idx = 0;
    logic [31:0] cyc_a = '0;
    int          errors = 0;
    int          rsp_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          errs_at_start;

    always #(CLK_PERIOD / 2) clock_a = ~clock_a;
    always #(CLK_PERIOD / 2) clock_b = ~clock_b;

    // Core cycle count for read tags
    always @(posedge clock_a) cyc_a <= cyc_a + 32'd1;

    vga_display_top #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) vga_display_top_inst (
        .clock_a  (clock_a),
        .clock_b  (clock_b),
        .arst_n   (arst_n),
        .core_req (core_req),
        .core_rsp (core_rsp),
        .video    (video)
    );

    bind vga_display_top vga_display_checker vga_display_checker_inst (
        .clock_a  (clock_a),
        .clock_b  (clock_b),
        .arst_n   (arst_n),
        .core_req (core_req),
        .core_rsp (core_rsp),
        .video    (video),
        .mem_wren (mem_wren)
    );

    // ==============================
    // Reference model
    // ==============================

    // Byte lanes of a write merged into the old word
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
            input logic [31:0] new_word, input logic [3:0] be);
        logic [31:0] res;
        res = old_word;
        if (be[0]) res[7:0] = new_word[7:0];
        if (be[1]) res[15:8] = new_word[15:8];
        if (be[2]) res[23:16] = new_word[23:16];
        if (be[3]) res[31:24] = new_word[31:24];
        return res;
    endfunction

    // Pixel (x, y), bit 0 of each word leftmost
    function automatic logic pixel_ref(input int x, input int y);
        logic [31:0] word;
        word = shadow[SH_AW'(y * WPL + x / 32)];
        return word[5'(x % 32)];
    endfunction

    function automatic int total_errors();
        return errors + rsp_errors + vga_display_top_inst.vga_display_checker_inst.assert_fails;
    endfunction

    // ==============================
    // Core side
    // ==============================

    // One request strobe on a falling edge of clock_a
    task automatic issue(input logic we, input logic [29:0] addr,
            input logic [31:0] data, input logic [3:0] be);
        logic     in_win;
        exp_rsp_t rsp;
        in_win           = addr < 30'(MEM_WORDS);
        core_req.valid   = 1'b1;
        core_req.we      = we;
        core_req.addr    = addr;
        core_req.data    = data;
        core_req.byteena = be;
        if (we && in_win) begin
            shadow[SH_AW'(addr)] = merge_bytes(shadow[SH_AW'(addr)], data, be);
        end else if (!we) begin
            rsp.cyc  = cyc_a;
            rsp.err  = !in_win;
            rsp.data = in_win ? shadow[SH_AW'(addr)] : 32'd0;
            exp_q.push_back(rsp);
        end
        @(negedge clock_a);
        core_req.valid = 1'b0;
    endtask

    // Response compare at the falling edge
    always @(negedge clock_a) begin
        if (arst_n && core_rsp.valid) begin
            if (rd_idx >= exp_q.size()) begin
                $display("core response arrived with no read outstanding");
                rsp_errors++;
            end else begin
                if (cyc_a - exp_q[rd_idx].cyc != 32'd2) begin
                    $display("ERR core_rsp.valid latency got %h exp %h",
                             cyc_a - exp_q[rd_idx].cyc, 32'd2);
                    rsp_errors++;
                end
                if (core_rsp.err != exp_q[rd_idx].err) begin
                    $display("ERR core_rsp.err got %h exp %h", core_rsp.err, exp_q[rd_idx].err);
                    rsp_errors++;
                end
                if (core_rsp.data != exp_q[rd_idx].data) begin
                    $display("ERR core_rsp.data got %h exp %h",
                             core_rsp.data, exp_q[rd_idx].data);
                    rsp_errors++;
                end
                rd_idx++;
            end
        end
    end

    // Wait for outstanding reads
    task automatic drain();
        int wait_cyc;
        wait_cyc = 0;
        while (rd_idx < exp_q.size() && wait_cyc < 8) begin
            @(negedge clock_a);
            wait_cyc++;
        end
        if (rd_idx < exp_q.size()) begin
            $display("%0d core reads never got a response", exp_q.size() - rd_idx);
            errors++;
        end
    endtask

    task automatic read_all();
        for (int w = 0; w < MEM_WORDS; w++) begin
            issue(1'b0, 30'(w), 32'd0, 4'h0);
        end
        drain();
    endtask

    // ==============================
    // Display side
    // ==============================
    task automatic wait_vsync_fall();
        logic prev;
        @(negedge clock_b);
        prev = video.vsync_n;
        @(negedge clock_b);
        while (!(prev && !video.vsync_n)) begin
            prev = video.vsync_n;
            @(negedge clock_b);
        end
    endtask

    // One frame from a vsync fall to the next
    task automatic check_timing();
        int   de_run;
        int   de_lines;
        int   hs_run;
        int   hs_runs;
        int   hs_last;
        int   vs_low;
        logic de_p;
        logic hs_p;
        logic vs_p;
        de_run = 0;
        de_lines = 0;
        hs_run = 0;
        hs_runs = 0;
        hs_last = -1;
        vs_low = 0;
        de_p = 1'b0;
        hs_p = 1'b1;
        vs_p = 1'b1;
        wait_vsync_fall();
        for (int c = 0; c < FRAME_CYC; c++) begin
            if (!video.vsync_n) vs_low++;
            if (video.de) begin
                de_run++;
            end else if (de_p) begin
                if (de_run != H_ACTIVE) begin
                    $display("ERR de run length got %h exp %h", de_run, H_ACTIVE);
                    errors++;
                end
                de_lines++;
                de_run = 0;
            end
            if (!video.hsync_n) begin
                // Line period measured between hsync falls
                if (hs_p) begin
                    if (hs_last >= 0 && c - hs_last != LINE_CYC) begin
                        $display("ERR hsync_n period got %h exp %h", c - hs_last, LINE_CYC);
                        errors++;
                    end
                    hs_last = c;
                    hs_runs++;
                end
                hs_run++;
            end else if (!hs_p) begin
                if (hs_run != H_SYNC) begin
                    $display("ERR hsync_n low length got %h exp %h", hs_run, H_SYNC);
                    errors++;
                end
                hs_run = 0;
            end
            de_p = video.de;
            hs_p = video.hsync_n;
            vs_p = video.vsync_n;
            @(negedge clock_b);
        end
        if (de_lines != V_ACTIVE) begin
            $display("ERR de lines per frame got %h exp %h", de_lines, V_ACTIVE);
            errors++;
        end
        if (hs_runs != V_ACTIVE + V_FRONT + V_SYNC + V_BACK) begin
            $display("ERR hsync_n pulses per frame got %h exp %h", hs_runs,
                     V_ACTIVE + V_FRONT + V_SYNC + V_BACK);
            errors++;
        end
        if (vs_low != V_SYNC * LINE_CYC) begin
            $display("ERR vsync_n low cycles got %h exp %h", vs_low, V_SYNC * LINE_CYC);
            errors++;
        end
        if (!(vs_p && !video.vsync_n)) begin
            $display("vsync_n did not fall again one frame period later");
            errors++;
        end
    endtask

    // Capture the next full frame and compare every pixel
    task automatic capture_frame();
        int x;
        int y;
        x = 0;
        y = 0;
        wait_vsync_fall();
        while (y < V_ACTIVE) begin
            @(negedge clock_b);
            if (video.de) begin
                if (video.pixel != pixel_ref(x, y)) begin
                    $display("ERR video.pixel x %0d y %0d got %h exp %h",
                             x, y, video.pixel, pixel_ref(x, y));
                    errors++;
                end
                x++;
                if (x == H_ACTIVE) begin
                    x = 0;
                    y++;
                end
            end
        end
    endtask

    // ==============================
    // Test bookkeeping
    // ==============================
    task automatic start_test();
        errs_at_start = total_errors();
    endtask

    task automatic finish_test(input string name);
        int n;
        n = total_errors() - errs_at_start;
        tests_run++;
        if (n == 0) begin
            $display("test %s ok", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, n);
        end
    endtask

    // Hang guard
    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("run did not finish within %0d cycles", WATCHDOG_CYC);
        $display("TEST FAILED");
        $finish;
    end

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        int          w;
        logic [29:0] oob [4];
        core_req = '0;
        arst_n   = 1'b1;
        // Reset edge just after time zero
        #1;
        arst_n = 1'b0;
        repeat (2) @(negedge clock_a);
        arst_n = 1'b1;
        @(negedge clock_a);

        start_test();
        for (int i = 0; i < MEM_WORDS; i++) begin
            issue(1'b1, 30'(i), $random(seed), 4'hf);
        end
        read_all();
        finish_test("full_word_rw");

        // Write then read straight behind it
        start_test();
        for (int i = 0; i < 20; i++) begin
            w = int'({$random(seed)} % MEM_WORDS);
            issue(1'b1, 30'(w), $random(seed), 4'({$random(seed)}));
            issue(1'b0, 30'(w), 32'd0, 4'h0);
        end
        read_all();
        finish_test("byte_enable");

        // 16 aliases word 0 once truncated
        start_test();
        oob[0] = 30'(MEM_WORDS);
        oob[1] = 30'(MEM_WORDS + 1);
        oob[2] = 30'd16;
        oob[3] = 30'h3fff_ffff;
        for (int i = 0; i < 4; i++) begin
            issue(1'b1, oob[i], $random(seed), 4'hf);
            issue(1'b0, oob[i], 32'd0, 4'h0);
        end
        read_all();
        finish_test("out_of_window");

        start_test();
        check_timing();
        finish_test("raster_timing");

        start_test();
        @(negedge clock_a);
        for (int i = 0; i < MEM_WORDS; i++) begin
            issue(1'b1, 30'(i), $random(seed), 4'hf);
        end
        capture_frame();
        finish_test("frame_content");

        // Rewrites land while the raster is inside the active area
        start_test();
        do @(negedge clock_b); while (!video.de);
        @(negedge clock_a);
        for (int i = 0; i < MEM_WORDS; i += 2) begin
            issue(1'b1, 30'(i), $random(seed), 4'({$random(seed)}));
        end
        capture_frame();
        finish_test("live_update");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors());
        if (total_errors() == 0 && tests_failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- vga_display.f
hdl/vga_pkg.sv
hdl/vga_core_port.sv
hdl/vga_mem.sv
hdl/vga_raster_timing.sv
hdl/vga_pixel_fetch.sv
hdl/vga_display_top.sv
sim/vga_display_checker.sv
sim/vga_display_tb.sv

//--- Makefile
# Verilator build and run of the VGA display testbench
# The run passes only if the log holds the pass line

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module vga_display_tb -f vga_display.f -o vga_display_sim
	./obj_dir/vga_display_sim +verilator+error+limit+1000 | tee sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
